/* hw/ac97_pkg.sv */
/*
 * shared constants of the audio stream controller
 * sample and FIFO sizes, register map, control, status and interrupt bit positions
 */

package ac97_pkg;

   // ------------------------------------------------------------
   // sample and FIFO sizes
   localparam int sample_w   = 16;             // one audio sample
   localparam int play_w     = 2 * sample_w;   // left in upper half, right in lower
   localparam int fifo_depth = 16;             // entries per FIFO
   localparam int fifo_aw    = 5;              // level counter, holds 0..16
   localparam int fifo_pw    = 4;              // read/write pointer width
   localparam int half_level = 8;              // play_low / capt_high threshold

   // ------------------------------------------------------------
   // register offsets on sys_addr[19:0]
   localparam logic [19:0] reg_ctrl      = 20'h00000;
   localparam logic [19:0] reg_status    = 20'h00004;   // read only
   localparam logic [19:0] reg_icr       = 20'h00008;
   localparam logic [19:0] reg_isr       = 20'h0000C;   // write one to clear sticky bits
   localparam logic [19:0] reg_play_data = 20'h00010;   // write only
   localparam logic [19:0] reg_capt_data = 20'h00014;   // read only, pops capture

   localparam int ctrl_enable = 0;             // stream port enable

   // ISR / ICR bits
   localparam int isr_w             = 4;
   localparam int isr_play_low      = 0;       // level
   localparam int isr_capt_high     = 1;       // level
   localparam int isr_play_underrun = 2;       // sticky
   localparam int isr_capt_overrun  = 3;       // sticky

   // status word fields
   localparam int stat_play_lvl   = 0;         // bits 4:0
   localparam int stat_capt_lvl   = 8;         // bits 12:8
   localparam int stat_play_full  = 16;
   localparam int stat_capt_empty = 17;

endpackage

/* hw/ac97_fifo_if.sv */
/*
 * push, pop and level signals of one sample FIFO
 */

`timescale 1ns/1ns

interface ac97_fifo_if #(
   parameter int data_w = ac97_pkg::play_w   // 32 for playback, 16 for capture
);
   import ac97_pkg::*;

   logic                push;          // ignored when full
   logic [data_w-1:0]   push_data;
   logic                pop;           // ignored when empty
   logic [data_w-1:0]   head_data;     // valid while empty is low
   logic [fifo_aw-1:0]  level;
   logic                full;
   logic                empty;

   modport producer (output push, push_data, input full, level);
   // level also seen here so the register block can report the capture fill
   modport consumer (output pop, input head_data, empty, level);
   modport store    (input push, push_data, pop, output head_data, level, full, empty);

endinterface

/* hw/ac97_frame_sync.sv */
/*
 * 48 kHz frame clock synchronizer and rising edge strobe
 */

`timescale 1ns/1ns

module ac97_frame_sync (
   input  logic clk_adc_125mhz,   // 125 MHz system clock
   input  logic adc_rstn_i,       // sync reset, active low
   input  logic clk_48khz,        // async frame clock
   output logic frame_stb         // one cycle per rising edge
);

   logic sync_1;                  // first synchronizer stage
   logic sync_2;                  // second stage, safe to use
   logic sync_3;                  // previous value for edge detect

   // ------------------------------------------------------------
   // two flop sync plus registered edge detect
   // edge to strobe is three clocks
   always_ff @(posedge clk_adc_125mhz) begin
      if (!adc_rstn_i) begin
         sync_1    <= 1'b0;
         sync_2    <= 1'b0;
         sync_3    <= 1'b0;
         frame_stb <= 1'b0;
      end else begin
         sync_1    <= clk_48khz;
         sync_2    <= sync_1;
         sync_3    <= sync_2;
         frame_stb <= sync_2 & ~sync_3;   // low to high only
      end
   end

endmodule

/* hw/ac97_sample_fifo.sv */
/*
 * first word fall through synchronous FIFO
 * circular buffer with read/write pointers and a level counter
 */

`timescale 1ns/1ns

module ac97_sample_fifo #(
   parameter int data_w = ac97_pkg::play_w   // must match the interface width
)(
   input  logic       clk_adc_125mhz,
   input  logic       adc_rstn_i,
   ac97_fifo_if.store fifo
);
   import ac97_pkg::*;

   logic [data_w-1:0]  mem [fifo_depth];   // sample storage
   logic [fifo_pw-1:0] wr_ptr;
   logic [fifo_pw-1:0] rd_ptr;
   logic [fifo_aw-1:0] level_q;
   logic               do_push;
   logic               do_pop;

   // flags straight from the counter
   assign fifo.full  = (level_q == fifo_aw'(fifo_depth));
   assign fifo.empty = (level_q == '0);
   assign fifo.level = level_q;

   assign fifo.head_data = mem[rd_ptr];     // fall through head

   assign do_push = fifo.push & ~fifo.full;   // drop when full
   assign do_pop  = fifo.pop  & ~fifo.empty;  // nothing to pop when empty

   // ------------------------------------------------------------
   // storage write
   always_ff @(posedge clk_adc_125mhz) begin
      if (do_push) begin
         mem[wr_ptr] <= fifo.push_data;
      end
   end

   // ------------------------------------------------------------
   // pointers and level
   always_ff @(posedge clk_adc_125mhz) begin
      if (!adc_rstn_i) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         level_q <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;         // both or neither
         endcase
      end
   end

endmodule

/* hw/ac97_stream_port.sv */
/*
 * per frame playback pop to the line outputs
 * and line input push to capture, with underrun/overrun pulses
 */

`timescale 1ns/1ns

module ac97_stream_port (
   input  logic                            clk_adc_125mhz,
   input  logic                            adc_rstn_i,
   input  logic                            enable,       // from ctrl register
   input  logic                            frame_stb,    // one cycle per frame
   input  logic [ac97_pkg::sample_w-1:0]   line_in,      // mono line input
   output logic [ac97_pkg::sample_w-1:0]   line_left,
   output logic [ac97_pkg::sample_w-1:0]   line_right,
   ac97_fifo_if.consumer                   play,
   ac97_fifo_if.producer                   capt,
   output logic                            underrun,     // one cycle pulse
   output logic                            overrun       // one cycle pulse
);
   import ac97_pkg::*;

   logic frame_act;   // strobe while enabled
   logic play_ok;     // a playback word is there

   assign frame_act = frame_stb & enable;
   assign play_ok   = ~play.empty;

   // ------------------------------------------------------------
   // FIFO side, all in the strobe cycle
   assign play.pop       = frame_act & play_ok;
   assign capt.push      = frame_act & ~capt.full;   // sample dropped when full
   assign capt.push_data = line_in;

   // ------------------------------------------------------------
   // line outputs one cycle after the strobe
   always_ff @(posedge clk_adc_125mhz) begin
      if (!adc_rstn_i) begin
         line_left  <= '0;
         line_right <= '0;
      end else if (!enable) begin
         line_left  <= '0;    // silent while disabled
         line_right <= '0;
      end else if (frame_stb) begin
         if (play_ok) begin
            line_left  <= play.head_data[play_w-1:sample_w];
            line_right <= play.head_data[sample_w-1:0];
         end else begin
            line_left  <= '0;   // underrun plays silence
            line_right <= '0;
         end
      end
   end

   // error pulses
   always_ff @(posedge clk_adc_125mhz) begin
      if (!adc_rstn_i) begin
         underrun <= 1'b0;
         overrun  <= 1'b0;
      end else begin
         underrun <= frame_act & ~play_ok;
         overrun  <= frame_act & capt.full;
      end
   end

endmodule

/* hw/ac97_ctrl_regs.sv */
/*
 * system bus register block
 * control, status, interrupt control/status, FIFO data ports and irq line
 */

`timescale 1ns/1ns

module ac97_ctrl_regs (
   input  logic                 clk_adc_125mhz,
   input  logic                 adc_rstn_i,
   // system bus
   input  logic [31:0]          sys_addr,
   input  logic [31:0]          sys_wdata,
   input  logic [ 3:0]          sys_sel,      // accepted, not used for writes
   input  logic                 sys_wen,      // one cycle write strobe
   input  logic                 sys_ren,      // one cycle read strobe
   output logic [31:0]          sys_rdata,
   output logic                 sys_err,
   output logic                 sys_ack,
   // stream port side
   output logic                 enable,
   input  logic                 underrun,
   input  logic                 overrun,
   ac97_fifo_if.producer        play,
   ac97_fifo_if.consumer        capt,
   output logic                 irq
);
   import ac97_pkg::*;

   logic [19:0]       addr_lo;      // decoded address bits
   logic [31:0]       ctrl_q;
   logic [31:0]       icr_q;
   logic [isr_w-1:0]  isr_q;
   logic [isr_w-1:0]  isr_clr;      // write one to clear
   logic [31:0]       status_w;
   logic [31:0]       rd_mux;
   logic              play_low;
   logic              capt_high;

   assign addr_lo = sys_addr[19:0];
   assign enable  = ctrl_q[ctrl_enable];

   // ------------------------------------------------------------
   // FIFO access, same cycle as the strobe
   assign play.push      = sys_wen & (addr_lo == reg_play_data);   // dropped when full
   assign play.push_data = sys_wdata;
   assign capt.pop       = sys_ren & (addr_lo == reg_capt_data);

   // level flags
   // only while enabled so an idle block reads all zero
   assign play_low  = enable & (play.level <  fifo_aw'(half_level));
   assign capt_high = enable & (capt.level >= fifo_aw'(half_level));

   assign isr_clr = (sys_wen && addr_lo == reg_isr) ? sys_wdata[isr_w-1:0] : '0;

   // ------------------------------------------------------------
   // status word and read mux
   always_comb begin
      status_w = '0;
      status_w[stat_play_lvl +: fifo_aw] = play.level;
      status_w[stat_capt_lvl +: fifo_aw] = capt.level;
      status_w[stat_play_full]           = play.full;
      status_w[stat_capt_empty]          = capt.empty;

      case (addr_lo)
         reg_ctrl:      rd_mux = ctrl_q;
         reg_status:    rd_mux = status_w;
         reg_icr:       rd_mux = icr_q;
         reg_isr:       rd_mux = 32'(isr_q);
         reg_capt_data: rd_mux = capt.empty ? 32'h0 : 32'(capt.head_data);   // zero extend
         default:       rd_mux = 32'h0;   // unknown and write only
      endcase
   end

   // ------------------------------------------------------------
   // writable registers
   always_ff @(posedge clk_adc_125mhz) begin
      if (!adc_rstn_i) begin
         ctrl_q <= '0;
         icr_q  <= '0;
      end else if (sys_wen) begin
         case (addr_lo)
            reg_ctrl: ctrl_q <= sys_wdata;
            reg_icr:  icr_q  <= sys_wdata;
            default:  ;   // other offsets have no storage here
         endcase
      end
   end

   // interrupt status, levels every cycle, error bits sticky
   always_ff @(posedge clk_adc_125mhz) begin
      if (!adc_rstn_i) begin
         isr_q <= '0;
         irq   <= 1'b0;
      end else begin
         isr_q[isr_play_low]  <= play_low;
         isr_q[isr_capt_high] <= capt_high;
         // set wins over a clear in the same cycle
         isr_q[isr_play_underrun] <= underrun |
            (isr_q[isr_play_underrun] & ~isr_clr[isr_play_underrun]);
         isr_q[isr_capt_overrun]  <= overrun |
            (isr_q[isr_capt_overrun] & ~isr_clr[isr_capt_overrun]);
         irq <= |(isr_q & icr_q[isr_w-1:0]);   // one cycle after the ISR bit
      end
   end

   // ------------------------------------------------------------
   // bus response, ack one cycle after any strobe
   always_ff @(posedge clk_adc_125mhz) begin
      if (!adc_rstn_i) begin
         sys_ack   <= 1'b0;
         sys_err   <= 1'b0;
         sys_rdata <= '0;
      end else begin
         sys_ack   <= sys_wen | sys_ren;
         sys_err   <= 1'b0;                    // never an error
         sys_rdata <= sys_ren ? rd_mux : 32'h0;
      end
   end

endmodule

/* hw/ac97_ctrl_top.sv */
/*
 * top level of the audio stream controller
 * frame sync, stream port, register block and the two sample FIFOs
 */

`timescale 1ns/1ns

module ac97_ctrl_top (
   input  logic                            clk_adc_125mhz,
   input  logic                            adc_rstn_i,
   input  logic                            clk_48khz,
   // line nodes
   input  logic [ac97_pkg::sample_w-1:0]   ac97_line_i,
   output logic [ac97_pkg::sample_w-1:0]   ac97_line_left_o,
   output logic [ac97_pkg::sample_w-1:0]   ac97_line_right_o,
   output logic                            ac97_irq_o,
   // system bus
   input  logic [31:0]                     sys_addr,
   input  logic [31:0]                     sys_wdata,
   input  logic [ 3:0]                     sys_sel,
   input  logic                            sys_wen,
   input  logic                            sys_ren,
   output logic [31:0]                     sys_rdata,
   output logic                            sys_err,
   output logic                            sys_ack
);
   import ac97_pkg::*;

   logic frame_stb;   // frame sync to stream port
   logic enable;
   logic underrun;
   logic overrun;

   ac97_fifo_if #(.data_w(play_w))   play_if ();   // regs -> stream port
   ac97_fifo_if #(.data_w(sample_w)) capt_if ();   // stream port -> regs

   // ------------------------------------------------------------
   ac97_frame_sync u_frame_sync (
      .clk_adc_125mhz (clk_adc_125mhz),
      .adc_rstn_i     (adc_rstn_i),
      .clk_48khz      (clk_48khz),
      .frame_stb      (frame_stb)
   );

   ac97_sample_fifo #(.data_w(play_w)) u_play_fifo (
      .clk_adc_125mhz (clk_adc_125mhz),
      .adc_rstn_i     (adc_rstn_i),
      .fifo           (play_if)
   );

   ac97_sample_fifo #(.data_w(sample_w)) u_capt_fifo (
      .clk_adc_125mhz (clk_adc_125mhz),
      .adc_rstn_i     (adc_rstn_i),
      .fifo           (capt_if)
   );

   ac97_stream_port u_stream_port (
      .clk_adc_125mhz (clk_adc_125mhz),
      .adc_rstn_i     (adc_rstn_i),
      .enable         (enable),
      .frame_stb      (frame_stb),
      .line_in        (ac97_line_i),
      .line_left      (ac97_line_left_o),
      .line_right     (ac97_line_right_o),
      .play           (play_if),
      .capt           (capt_if),
      .underrun       (underrun),
      .overrun        (overrun)
   );

   ac97_ctrl_regs u_ctrl_regs (
      .clk_adc_125mhz (clk_adc_125mhz),
      .adc_rstn_i     (adc_rstn_i),
      .sys_addr       (sys_addr),
      .sys_wdata      (sys_wdata),
      .sys_sel        (sys_sel),
      .sys_wen        (sys_wen),
      .sys_ren        (sys_ren),
      .sys_rdata      (sys_rdata),
      .sys_err        (sys_err),
      .sys_ack        (sys_ack),
      .enable         (enable),
      .underrun       (underrun),
      .overrun        (overrun),
      .play           (play_if),
      .capt           (capt_if),
      .irq            (ac97_irq_o)
   );

endmodule

/* test/ac97_tb.sv */
/*
 * testbench for the audio stream controller
 * step table, bus driver, frame clock, reference model and compare tasks
 */

`timescale 1ns/1ns

module ac97_tb;
   import ac97_pkg::*;

   localparam int op_wr   = 0;   // bus write, data from table
   localparam int op_rd   = 1;   // bus read, expected value from table
   localparam int op_chk  = 2;   // bus read, expected value from model
   localparam int op_play = 3;   // write n random playback words
   localparam int op_frm  = 4;   // n frame clock edges
   localparam logic [11:0] addr_hi = 12'h403;   // ignored by the decode

   typedef struct {
      int          op;
      logic [31:0] addr;
      logic [31:0] data;   // write data or count
      logic [31:0] exp;
   } step_t;

   logic                clk_adc_125mhz;
   logic                adc_rstn_i;
   logic                clk_48khz;
   logic [sample_w-1:0] line_i;
   logic [sample_w-1:0] line_left;
   logic [sample_w-1:0] line_right;
   logic                irq;
   logic [31:0]         sys_addr;
   logic [31:0]         sys_wdata;
   logic [3:0]          sys_sel;
   logic                sys_wen;
   logic                sys_ren;
   logic [31:0]         sys_rdata;
   logic                sys_err;
   logic                sys_ack;

   // reference model state
   step_t               steps[$];
   logic [play_w-1:0]   play_q[$];
   logic [sample_w-1:0] capt_q[$];
   logic [31:0]         ctrl_m;
   logic [31:0]         icr_m;
   logic                under_m;
   logic                over_m;
   logic [sample_w-1:0] left_m;
   logic [sample_w-1:0] right_m;
   int                  cycles = 0;
   int                  limit;

   ac97_ctrl_top DUT (
      .clk_adc_125mhz    (clk_adc_125mhz),
      .adc_rstn_i        (adc_rstn_i),
      .clk_48khz         (clk_48khz),
      .ac97_line_i       (line_i),
      .ac97_line_left_o  (line_left),
      .ac97_line_right_o (line_right),
      .ac97_irq_o        (irq),
      .sys_addr          (sys_addr),
      .sys_wdata         (sys_wdata),
      .sys_sel           (sys_sel),
      .sys_wen           (sys_wen),
      .sys_ren           (sys_ren),
      .sys_rdata         (sys_rdata),
      .sys_err           (sys_err),
      .sys_ack           (sys_ack)
   );

   initial begin
      clk_adc_125mhz = 1'b0;
      forever #4 clk_adc_125mhz = ~clk_adc_125mhz;   // 125 MHz
   end

   // ------------------------------------------------------------
   // failure reporting and compare tasks
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp) fail_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_sample(input string name, input logic [sample_w-1:0] got,
                               input logic [sample_w-1:0] exp);
      if (got !== exp) fail_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) fail_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
   endtask

   always @(posedge clk_adc_125mhz) begin
      cycles = cycles + 1;
      if (cycles > limit) fail_run("timeout, the run went past its cycle limit");
   end

   // ------------------------------------------------------------
   // reference model
   function automatic logic [isr_w-1:0] isr_model();
      logic [isr_w-1:0] v;
      v = '0;
      v[isr_play_low]      = ctrl_m[ctrl_enable] && (play_q.size() < half_level);
      v[isr_capt_high]     = ctrl_m[ctrl_enable] && (capt_q.size() >= half_level);
      v[isr_play_underrun] = under_m;   // sticky
      v[isr_capt_overrun]  = over_m;
      return v;
   endfunction

   function automatic logic [31:0] status_model();
      logic [31:0] v;
      v = '0;
      v[stat_play_lvl +: fifo_aw] = fifo_aw'(play_q.size());
      v[stat_capt_lvl +: fifo_aw] = fifo_aw'(capt_q.size());
      v[stat_play_full]           = (play_q.size() == fifo_depth);
      v[stat_capt_empty]          = (capt_q.size() == 0);
      return v;
   endfunction

   // capture data read pops the model too
   function automatic logic [31:0] read_model(input logic [31:0] addr);
      logic [31:0] v;
      v = 32'h0;
      case (addr[19:0])
         reg_ctrl:      v = ctrl_m;
         reg_status:    v = status_model();
         reg_icr:       v = icr_m;
         reg_isr:       v = 32'(isr_model());
         reg_capt_data: if (capt_q.size() > 0) v = 32'(capt_q.pop_front());
         default:       v = 32'h0;   // unknown or write only
      endcase
      return v;
   endfunction

   task automatic write_model(input logic [31:0] addr, input logic [31:0] data);
      case (addr[19:0])
         reg_ctrl: begin
            ctrl_m = data;
            if (!data[ctrl_enable]) begin
               left_m  = '0;   // outputs forced silent
               right_m = '0;
            end
         end
         reg_icr: icr_m = data;
         reg_isr: begin
            if (data[isr_play_underrun]) under_m = 1'b0;
            if (data[isr_capt_overrun])  over_m  = 1'b0;
         end
         reg_play_data: if (play_q.size() < fifo_depth) play_q.push_back(data);
         default: ;
      endcase
   endtask

   task automatic frame_model(input logic [sample_w-1:0] smp);
      logic [play_w-1:0] w;
      if (ctrl_m[ctrl_enable]) begin
         if (play_q.size() > 0) begin
            w       = play_q.pop_front();
            left_m  = w[play_w-1:sample_w];   // left in upper half
            right_m = w[sample_w-1:0];
         end else begin
            left_m  = '0;
            right_m = '0;
            under_m = 1'b1;
         end
         if (capt_q.size() < fifo_depth) capt_q.push_back(smp);
         else over_m = 1'b1;                  // sample dropped
      end
   endtask

   // ------------------------------------------------------------
   // bus and frame drivers, all inputs change on the falling edge
   task automatic bus_op(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                         output logic [31:0] rdata);
      @(negedge clk_adc_125mhz);
      sys_addr  = addr;
      sys_wdata = wr ? data : 32'h0;
      sys_wen   = wr;
      sys_ren   = ~wr;
      @(negedge clk_adc_125mhz);
      sys_wen = 1'b0;
      sys_ren = 1'b0;
      if (sys_ack !== 1'b1) fail_run("no acknowledge one cycle after the bus strobe");
      check_bit("sys_err", sys_err, 1'b0);
      rdata = sys_rdata;
      @(negedge clk_adc_125mhz);
      if (sys_ack !== 1'b0) fail_run("acknowledge held longer than one cycle");
      @(negedge clk_adc_125mhz);   // level -> isr -> irq settles
   endtask

   task automatic frame_edges(input logic [31:0] n);
      logic [sample_w-1:0] smp;
      repeat (n) begin
         @(negedge clk_adc_125mhz);
         smp       = sample_w'($urandom);
         line_i    = smp;              // held over the whole frame
         clk_48khz = 1'b1;
         frame_model(smp);
         repeat (40) @(negedge clk_adc_125mhz);
         check_sample("ac97_line_left_o", line_left, left_m);
         check_sample("ac97_line_right_o", line_right, right_m);
         clk_48khz = 1'b0;
         repeat (40) @(negedge clk_adc_125mhz);
      end
   endtask

   task automatic add_step(input int op, input logic [19:0] off, input logic [31:0] data,
                           input logic [31:0] exp);
      step_t s;
      s.op   = op;
      s.addr = {addr_hi, off};
      s.data = data;
      s.exp  = exp;
      steps.push_back(s);
   endtask

   // ------------------------------------------------------------
   // step table
   task automatic build_table();
      // reset values, unknown and write only offsets
      add_step(op_rd, reg_ctrl, 0, 0);
      add_step(op_rd, reg_status, 0, 32'h0002_0000);   // capture empty
      add_step(op_rd, reg_icr, 0, 0);
      add_step(op_rd, reg_isr, 0, 0);
      add_step(op_rd, reg_play_data, 0, 0);
      add_step(op_rd, 20'h00040, 0, 0);
      add_step(op_rd, reg_capt_data, 0, 0);
      // read back
      add_step(op_wr, reg_icr, 32'hA5A5_0000, 0);
      add_step(op_rd, reg_icr, 0, 32'hA5A5_0000);
      add_step(op_wr, reg_icr, 0, 0);
      add_step(op_wr, reg_ctrl, 32'h1, 0);
      add_step(op_rd, reg_ctrl, 0, 32'h1);
      add_step(op_chk, reg_isr, 0, 0);                 // play low once enabled
      // playback order, last frame runs dry
      add_step(op_play, reg_play_data, 4, 0);
      add_step(op_chk, reg_status, 0, 0);
      add_step(op_frm, 20'h0, 5, 0);
      add_step(op_chk, reg_isr, 0, 0);
      add_step(op_wr, reg_icr, 32'h4, 0);              // irq on underrun
      add_step(op_wr, reg_isr, 32'h4, 0);              // clear, irq drops
      add_step(op_chk, reg_isr, 0, 0);
      // capture order, then one read while empty
      repeat (6) add_step(op_chk, reg_capt_data, 0, 0);
      add_step(op_chk, reg_status, 0, 0);
      // disabled port stays silent
      add_step(op_play, reg_play_data, 3, 0);
      add_step(op_frm, 20'h0, 1, 0);                   // outputs carry a word
      add_step(op_wr, reg_ctrl, 32'h0, 0);
      add_step(op_frm, 20'h0, 2, 0);
      add_step(op_chk, reg_status, 0, 0);
      add_step(op_wr, reg_ctrl, 32'h1, 0);
      // capture high, then overrun
      add_step(op_wr, reg_icr, 32'h2, 0);
      add_step(op_frm, 20'h0, 9, 0);
      add_step(op_chk, reg_isr, 0, 0);
      add_step(op_frm, 20'h0, 9, 0);                   // 19 samples, 3 dropped
      add_step(op_chk, reg_isr, 0, 0);
      add_step(op_wr, reg_icr, 32'h8, 0);
      add_step(op_wr, reg_isr, 32'hC, 0);
      add_step(op_chk, reg_isr, 0, 0);
      // play low around half_level, then full
      add_step(op_wr, reg_icr, 32'h1, 0);
      add_step(op_play, reg_play_data, 9, 0);
      add_step(op_chk, reg_status, 0, 0);
      add_step(op_play, reg_play_data, 8, 0);          // last word dropped
      add_step(op_chk, reg_status, 0, 0);
      add_step(op_chk, reg_capt_data, 0, 0);
      add_step(op_chk, reg_capt_data, 0, 0);
      add_step(op_chk, reg_isr, 0, 0);
   endtask

   function automatic int edge_count();
      int n;
      n = 0;
      foreach (steps[i]) if (steps[i].op == op_frm) n += int'(steps[i].data);
      return n;
   endfunction

   // ------------------------------------------------------------
   initial begin
      step_t       s;
      logic [31:0] rd;
      logic [31:0] exp;
      logic [31:0] word;
      void'($urandom(32'hf946339d));
      adc_rstn_i = 1'b0;
      clk_48khz  = 1'b0;
      line_i     = '0;
      sys_addr   = '0;
      sys_wdata  = '0;
      sys_sel    = 4'hF;
      sys_wen    = 1'b0;
      sys_ren    = 1'b0;
      ctrl_m     = '0;
      icr_m      = '0;
      under_m    = 1'b0;
      over_m     = 1'b0;
      left_m     = '0;
      right_m    = '0;
      build_table();
      limit = 200 * (steps.size() + edge_count());   // one frame edge is 80 cycles
      repeat (10) @(negedge clk_adc_125mhz);
      adc_rstn_i = 1'b1;

      foreach (steps[i]) begin
         s = steps[i];
         case (s.op)
            op_wr: begin
               bus_op(1'b1, s.addr, s.data, rd);
               write_model(s.addr, s.data);
            end
            op_rd: begin
               bus_op(1'b0, s.addr, 32'h0, rd);
               void'(read_model(s.addr));
               check_word("sys_rdata", rd, s.exp);
            end
            op_chk: begin
               bus_op(1'b0, s.addr, 32'h0, rd);
               exp = read_model(s.addr);
               check_word("sys_rdata", rd, exp);
            end
            op_play: begin
               repeat (s.data) begin
                  word = $urandom;
                  bus_op(1'b1, s.addr, word, rd);
                  write_model(s.addr, word);
               end
            end
            default: frame_edges(s.data);
         endcase
         check_bit("ac97_irq_o", irq, |(isr_model() & icr_m[isr_w-1:0]));
      end

      $display("Test passed");
      $finish;
   end

endmodule

/* sources.f */
hw/ac97_pkg.sv
hw/ac97_fifo_if.sv
hw/ac97_frame_sync.sv
hw/ac97_sample_fifo.sv
hw/ac97_stream_port.sv
hw/ac97_ctrl_regs.sv
hw/ac97_ctrl_top.sv
test/ac97_tb.sv

/* Makefile */
# Verilator lint, simulation and clean for the audio stream controller
# any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= ac97_tb
RTL_TOP   ?= ac97_ctrl_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o $(TB_TOP)

sim: build
	-./$(OBJ_DIR)/$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
